// File: hw/fpPkg.sv
/*
 * fpPkg
 * shared constants for the single-precision multiplier: format fields,
 * special values, rounding-mode codes, register map and status bits
 */
`default_nettype none

package fpPkg;

	// --------------------------------------------------
	// IEEE 754 single format
	// --------------------------------------------------
	localparam int FpWidth = 32;
	localparam int ExpWidth = 8;
	localparam int FracWidth = 23;
	localparam int ExpBias = 127;
	// all-ones exponent marks inf or NaN
	localparam logic [ExpWidth-1:0] ExpInf = '1;
	localparam logic [FpWidth-1:0] QuietNan = 32'h7FC0_0000;
	// 24x24 mantissa product
	localparam int ProdWidth = 2 * (FracWidth + 1);

	// rounding modes
	localparam logic [2:0] RmNearestEven = 3'd0;
	localparam logic [2:0] RmTowardZero = 3'd1;
	localparam logic [2:0] RmUp = 3'd2;
	localparam logic [2:0] RmDown = 3'd3;
	localparam logic [2:0] RmNearestAway = 3'd4;

	// --------------------------------------------------
	// AXI4-Lite register map, byte offsets
	// --------------------------------------------------
	localparam logic [4:0] AddrOpA = 5'h00;
	localparam logic [4:0] AddrOpB = 5'h04;
	localparam logic [4:0] AddrMode = 5'h08;
	localparam logic [4:0] AddrStart = 5'h0C;
	localparam logic [4:0] AddrResult = 5'h10;
	localparam logic [4:0] AddrStatus = 5'h14;

	// clocks from operand capture to rounded result
	localparam int MulLatency = 4;

	// status register bit positions
	localparam int StDone = 0;
	localparam int StBusy = 1;
	localparam int StInf = 2;
	localparam int StOverflow = 3;
	localparam int StUnderflow = 4;

endpackage

`default_nettype wire

// File: hw/fpDelay.sv
/*
 * fpDelay
 * shift register of Depth stages advancing on ce, carrying any payload type
 */
`timescale 1ns/1ps
`default_nettype none

module fpDelay #(
	parameter int Depth = 1,
	parameter type PayloadT = logic
) (
	input logic clk,
	input logic ce,
	input PayloadT din,
	output PayloadT dout
);

	PayloadT stages [Depth];

	always_ff @(posedge clk) begin
		if (ce) begin
			stages[0] <= din;
			// each stage takes the one before it
			for (int i = 1; i < Depth; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign dout = stages[Depth-1];

endmodule

`default_nettype wire

// File: hw/latencyTimer.sv
/*
 * latencyTimer
 * down-counter loaded on launch, pulses done Latency cycles later
 */
`timescale 1ns/1ps
`default_nettype none

module latencyTimer #(
	parameter int Latency = 4
) (
	input logic clk,
	input logic rst,
	input logic launch,
	output logic busy,
	output logic done
);

	localparam int CntWidth = $clog2(Latency + 1);

	logic [CntWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (launch) begin
			count <= CntWidth'(Latency);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// last count value is the done cycle
	assign busy = (count != '0);
	assign done = (count == CntWidth'(1));

endmodule

`default_nettype wire

// File: hw/fpMultiply.sv
/*
 * fpMultiply
 * operand decode, exponent sum and 24x24 mantissa multiply over two clocks
 * second clock also folds the operand classes into nan/inf/zero flags
 */
`timescale 1ns/1ps
`default_nettype none

module fpMultiply
	import fpPkg::*;
(
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [FpWidth-1:0] opA,
	input logic [FpWidth-1:0] opB,
	output logic [ProdWidth-1:0] product,
	output logic signed [ExpWidth+1:0] expSum,
	output logic sign,
	output logic nanOut,
	output logic infOut,
	output logic zeroOut
);

	localparam int MantWidth = FracWidth + 1;
	localparam int HalfWidth = MantWidth / 2;

	logic [ExpWidth-1:0] expA;
	logic [ExpWidth-1:0] expB;
	logic [FracWidth-1:0] fracA;
	logic [FracWidth-1:0] fracB;
	logic zeroA;
	logic zeroB;
	logic [MantWidth-1:0] mantA;
	logic [MantWidth-1:0] mantB;
	logic [ExpWidth+1:0] expSumNext;
	logic [6:0] classNow;
	logic [6:0] classDly;

	// partial products and exponent, first clock
	logic [2*HalfWidth-1:0] ppLL;
	logic [2*HalfWidth-1:0] ppHL;
	logic [2*HalfWidth-1:0] ppLH;
	logic [2*HalfWidth-1:0] ppHH;
	logic signed [ExpWidth+1:0] expSum1;

	// delayed operand classes
	logic signDly;
	logic nanADly;
	logic nanBDly;
	logic infADly;
	logic infBDly;
	logic zeroADly;
	logic zeroBDly;
	logic isNan;

	// --------------------------------------------------
	// first clock
	// --------------------------------------------------
	assign expA = opA[FpWidth-2 -: ExpWidth];
	assign expB = opB[FpWidth-2 -: ExpWidth];
	assign fracA = opA[FracWidth-1:0];
	assign fracB = opB[FracWidth-1:0];

	// zero exponent covers both zero and denormal, flushed here
	assign zeroA = (expA == '0);
	assign zeroB = (expB == '0);
	assign mantA = zeroA ? '0 : {1'b1, fracA};
	assign mantB = zeroB ? '0 : {1'b1, fracB};

	// biased sum minus bias, wraps to the signed range on purpose
	assign expSumNext = {2'b00, expA} + {2'b00, expB} - (ExpWidth+2)'(ExpBias);

	// sign, nanA, nanB, infA, infB, zeroA, zeroB
	assign classNow = {
		opA[FpWidth-1] ^ opB[FpWidth-1],
		(expA == ExpInf) && (fracA != '0),
		(expB == ExpInf) && (fracB != '0),
		(expA == ExpInf) && (fracA == '0),
		(expB == ExpInf) && (fracB == '0),
		zeroA,
		zeroB
	};

	always_ff @(posedge clk) begin
		if (ce) begin
			ppLL <= mantA[HalfWidth-1:0] * mantB[HalfWidth-1:0];
			ppHL <= mantA[MantWidth-1:HalfWidth] * mantB[HalfWidth-1:0];
			ppLH <= mantA[HalfWidth-1:0] * mantB[MantWidth-1:HalfWidth];
			ppHH <= mantA[MantWidth-1:HalfWidth] * mantB[MantWidth-1:HalfWidth];
			expSum1 <= expSumNext;
		end
	end

	// classes ride one stage alongside the partial products
	fpDelay #(
		.Depth(1),
		.PayloadT(logic [6:0])
	) u_classDelay (
		.clk(clk),
		.ce(ce),
		.din(classNow),
		.dout(classDly)
	);

	// --------------------------------------------------
	// second clock
	// --------------------------------------------------
	assign {signDly, nanADly, nanBDly, infADly, infBDly, zeroADly, zeroBDly} = classDly;

	// NaN operand, or inf times zero
	assign isNan = nanADly || nanBDly || (infADly && zeroBDly) || (infBDly && zeroADly);

	always_ff @(posedge clk) begin
		if (ce) begin
			// outer products overlap at the middle 12-bit offset
			product <= {ppHH, ppLL} + {ppHL, {HalfWidth{1'b0}}} + {ppLH, {HalfWidth{1'b0}}};
			expSum <= expSum1;
		end
	end

	// exception correction, flags kept mutually exclusive
	always_ff @(posedge clk) begin
		if (rst) begin
			sign <= 1'b0;
			nanOut <= 1'b0;
			infOut <= 1'b0;
			zeroOut <= 1'b0;
		end else if (ce) begin
			sign <= signDly;
			nanOut <= isNan;
			infOut <= !isNan && (infADly || infBDly);
			zeroOut <= !isNan && !(infADly || infBDly) && (zeroADly || zeroBDly);
		end
	end

endmodule

`default_nettype wire

// File: hw/fpNormalize.sv
/*
 * fpNormalize
 * puts the leading one of the 48-bit product at the hidden-bit position,
 * adjusts the exponent and reduces the tail to guard and sticky
 */
`timescale 1ns/1ps
`default_nettype none

module fpNormalize
	import fpPkg::*;
(
	input logic clk,
	input logic ce,
	input logic [ProdWidth-1:0] product,
	input logic signed [ExpWidth+1:0] expSum,
	input logic signIn,
	input logic nanIn,
	input logic infIn,
	input logic zeroIn,
	output logic [FracWidth+2:0] fraction,
	output logic signed [ExpWidth+1:0] expNorm,
	output logic signOut,
	output logic nanOut,
	output logic infOut,
	output logic zeroOut
);

	localparam int MantWidth = FracWidth + 1;

	logic topSet;
	logic [MantWidth-1:0] mantNext;
	logic guardNext;
	logic stickyNext;

	// product of two 1.x values lies in [1,4)
	assign topSet = product[ProdWidth-1];

	always_comb begin
		if (topSet) begin
			// 1x.xxx so shift right by one
			mantNext = product[ProdWidth-1 -: MantWidth];
			guardNext = product[ProdWidth-MantWidth-1];
			stickyNext = |product[ProdWidth-MantWidth-2:0];
		end else begin
			mantNext = product[ProdWidth-2 -: MantWidth];
			guardNext = product[ProdWidth-MantWidth-2];
			stickyNext = |product[ProdWidth-MantWidth-3:0];
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			// mantissa, guard, sticky
			fraction <= {mantNext, guardNext, stickyNext};
			expNorm <= expSum + (ExpWidth+2)'(topSet);
			signOut <= signIn;
			nanOut <= nanIn;
			infOut <= infIn;
			zeroOut <= zeroIn;
		end
	end

endmodule

`default_nettype wire

// File: hw/fpRound.sv
/*
 * fpRound
 * applies the rounding mode and packs the final single-precision word,
 * with NaN, infinity, overflow and underflow handling
 */
`timescale 1ns/1ps
`default_nettype none

module fpRound
	import fpPkg::*;
(
	input logic clk,
	input logic ce,
	input logic [2:0] roundMode,
	input logic [FracWidth+2:0] fraction,
	input logic signed [ExpWidth+1:0] expNorm,
	input logic signIn,
	input logic nanIn,
	input logic infIn,
	input logic zeroIn,
	output logic [FpWidth-1:0] result,
	output logic infFlag,
	output logic overflow,
	output logic underflow
);

	// mode enters with the operands, needed in the last stage
	localparam int ModeDepth = MulLatency - 1;

	logic [2:0] modeAligned;
	logic lsb;
	logic guard;
	logic sticky;
	logic roundUp;
	logic [FracWidth+1:0] mantRounded;
	logic carry;
	logic signed [ExpWidth+1:0] expFinal;

	fpDelay #(
		.Depth(ModeDepth),
		.PayloadT(logic [2:0])
	) u_modeDelay (
		.clk(clk),
		.ce(ce),
		.din(roundMode),
		.dout(modeAligned)
	);

	assign lsb = fraction[2];
	assign guard = fraction[1];
	assign sticky = fraction[0];

	always_comb begin
		case (modeAligned)
			RmNearestEven: roundUp = guard && (sticky || lsb);
			RmTowardZero: roundUp = 1'b0;
			RmUp: roundUp = !signIn && (guard || sticky);
			RmDown: roundUp = signIn && (guard || sticky);
			RmNearestAway: roundUp = guard;
			// reserved codes behave as nearest-even
			default: roundUp = guard && (sticky || lsb);
		endcase
	end

	assign mantRounded = {1'b0, fraction[FracWidth+2:2]} + (FracWidth+2)'(roundUp);

	// carry out means all-ones rolled over, stored fraction is already zero
	assign carry = mantRounded[FracWidth+1];
	assign expFinal = expNorm + (ExpWidth+2)'(carry);

	// --------------------------------------------------
	// result packing
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (ce) begin
			infFlag <= 1'b0;
			overflow <= 1'b0;
			underflow <= 1'b0;
			if (nanIn) begin
				result <= QuietNan;
			end else if (infIn) begin
				result <= {signIn, ExpInf, {FracWidth{1'b0}}};
				infFlag <= 1'b1;
			end else if (zeroIn) begin
				result <= {signIn, {(FpWidth-1){1'b0}}};
			end else if (expFinal >= $signed({2'b00, ExpInf})) begin
				// too large, saturate to signed inf
				result <= {signIn, ExpInf, {FracWidth{1'b0}}};
				overflow <= 1'b1;
			end else if (expFinal <= 0) begin
				// below smallest normal, flush
				result <= {signIn, {(FpWidth-1){1'b0}}};
				underflow <= 1'b1;
			end else begin
				result <= {signIn, expFinal[ExpWidth-1:0], mantRounded[FracWidth-1:0]};
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/mulSequencer.sv
/*
 * mulSequencer
 * AXI4-Lite slave for the multiplier: operand, mode and result registers,
 * start decode and status, with independent write and read FSMs
 */
`timescale 1ns/1ps
`default_nettype none

module mulSequencer
	import fpPkg::*;
(
	input logic clk,
	input logic rst,
	input logic [4:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [4:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [FpWidth-1:0] opA,
	output logic [FpWidth-1:0] opB,
	output logic [2:0] roundMode,
	output logic launch,
	input logic timerBusy,
	input logic done,
	input logic [FpWidth-1:0] result,
	input logic infFlag,
	input logic overflow,
	input logic underflow
);

	typedef enum logic {WrIdle, WrResp} wrStateT;
	typedef enum logic {RdIdle, RdResp} rdStateT;

	wrStateT wrState;
	rdStateT rdState;
	logic busy;
	logic wrTake;
	logic startHit;
	logic [FpWidth-1:0] resultReg;
	logic statusDone;
	logic statusInf;
	logic statusOver;
	logic statusUnder;
	logic [31:0] statusWord;
	logic [31:0] readWord;

	// byte-lane merge for partial writes
	function automatic logic [31:0] mergeBytes(
		input logic [31:0] old,
		input logic [31:0] data,
		input logic [3:0] strb
	);
		logic [31:0] merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				merged[8*b +: 8] = data[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// busy from the launch cycle until the done edge
	assign busy = launch || timerBusy;

	assign wrTake = (wrState == WrIdle) && awvalid && wvalid;
	assign startHit = wrTake && (awaddr == AddrStart) && wstrb[0] && wdata[0] && !busy;

	// always OKAY
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// --------------------------------------------------
	// write channel and register writes
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wrState <= WrIdle;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			launch <= 1'b0;
			opA <= '0;
			opB <= '0;
			roundMode <= '0;
		end else begin
			launch <= startHit;
			case (wrState)
				WrIdle: begin
					if (wrTake) begin
						awready <= 1'b1;
						wready <= 1'b1;
						wrState <= WrResp;
						case (awaddr)
							AddrOpA: opA <= mergeBytes(opA, wdata, wstrb);
							AddrOpB: opB <= mergeBytes(opB, wdata, wstrb);
							AddrMode: begin
								if (wstrb[0]) begin
									roundMode <= wdata[2:0];
								end
							end
							default: ;
						endcase
					end
				end
				WrResp: begin
					awready <= 1'b0;
					wready <= 1'b0;
					// response follows the accept cycle
					if (awready) begin
						bvalid <= 1'b1;
					end else if (bready) begin
						bvalid <= 1'b0;
						wrState <= WrIdle;
					end
				end
				default: wrState <= WrIdle;
			endcase
		end
	end

	// --------------------------------------------------
	// completion capture, independent of bus stalls
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			resultReg <= '0;
			statusDone <= 1'b0;
			statusInf <= 1'b0;
			statusOver <= 1'b0;
			statusUnder <= 1'b0;
		end else if (done) begin
			resultReg <= result;
			statusDone <= 1'b1;
			statusInf <= infFlag;
			statusOver <= overflow;
			statusUnder <= underflow;
		end else if (startHit) begin
			statusDone <= 1'b0;
		end
	end

	always_comb begin
		statusWord = '0;
		statusWord[StDone] = statusDone;
		statusWord[StBusy] = busy;
		statusWord[StInf] = statusInf;
		statusWord[StOverflow] = statusOver;
		statusWord[StUnderflow] = statusUnder;
	end

	// read mux, start and unknown offsets read zero
	always_comb begin
		readWord = '0;
		case (araddr)
			AddrOpA: readWord = opA;
			AddrOpB: readWord = opB;
			AddrMode: readWord[2:0] = roundMode;
			AddrResult: readWord = resultReg;
			AddrStatus: readWord = statusWord;
			default: ;
		endcase
	end

	// --------------------------------------------------
	// read channel
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rdState <= RdIdle;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
		end else begin
			case (rdState)
				RdIdle: begin
					if (arvalid) begin
						arready <= 1'b1;
						rdState <= RdResp;
					end
				end
				RdResp: begin
					arready <= 1'b0;
					// araddr still held during the accept cycle
					if (arready) begin
						rvalid <= 1'b1;
						rdata <= readWord;
					end else if (rready) begin
						rvalid <= 1'b0;
						rdState <= RdIdle;
					end
				end
				default: rdState <= RdIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/fpMulAxi.sv
/*
 * fpMulAxi
 * single-precision multiplier behind an AXI4-Lite slave
 */
`timescale 1ns/1ps
`default_nettype none

module fpMulAxi
	import fpPkg::*;
#(
	parameter int Latency = MulLatency
) (
	input logic clk,
	input logic rst,
	input logic [4:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [4:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	// pipeline runs every clock
	logic ce;

	logic [FpWidth-1:0] opA;
	logic [FpWidth-1:0] opB;
	logic [2:0] roundMode;
	logic launch;
	logic timerBusy;
	logic timerDone;

	// multiply to normalize
	logic [ProdWidth-1:0] mulProduct;
	logic signed [ExpWidth+1:0] mulExp;
	logic mulSign;
	logic mulNan;
	logic mulInf;
	logic mulZero;

	// normalize to round
	logic [FracWidth+2:0] normFrac;
	logic signed [ExpWidth+1:0] normExp;
	logic normSign;
	logic normNan;
	logic normInf;
	logic normZero;

	// round back to the sequencer
	logic [FpWidth-1:0] rndResult;
	logic rndInf;
	logic rndOver;
	logic rndUnder;

	assign ce = 1'b1;

	mulSequencer u_mulSequencer (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.opA(opA), .opB(opB), .roundMode(roundMode), .launch(launch),
		.timerBusy(timerBusy), .done(timerDone),
		.result(rndResult), .infFlag(rndInf), .overflow(rndOver), .underflow(rndUnder)
	);

	latencyTimer #(
		.Latency(Latency)
	) u_latencyTimer (
		.clk(clk), .rst(rst), .launch(launch), .busy(timerBusy), .done(timerDone)
	);

	fpMultiply u_fpMultiply (
		.clk(clk), .rst(rst), .ce(ce),
		.opA(opA), .opB(opB),
		.product(mulProduct), .expSum(mulExp), .sign(mulSign),
		.nanOut(mulNan), .infOut(mulInf), .zeroOut(mulZero)
	);

	fpNormalize u_fpNormalize (
		.clk(clk), .ce(ce),
		.product(mulProduct), .expSum(mulExp),
		.signIn(mulSign), .nanIn(mulNan), .infIn(mulInf), .zeroIn(mulZero),
		.fraction(normFrac), .expNorm(normExp),
		.signOut(normSign), .nanOut(normNan), .infOut(normInf), .zeroOut(normZero)
	);

	fpRound u_fpRound (
		.clk(clk), .ce(ce), .roundMode(roundMode),
		.fraction(normFrac), .expNorm(normExp),
		.signIn(normSign), .nanIn(normNan), .infIn(normInf), .zeroIn(normZero),
		.result(rndResult), .infFlag(rndInf), .overflow(rndOver), .underflow(rndUnder)
	);

endmodule

`default_nettype wire

// File: test/fpMulModel.svh
/*
 * fpMulModel
 * reference single-precision multiply and LFSR step for the testbench
 */
`ifndef FP_MUL_MODEL_SVH
`define FP_MUL_MODEL_SVH

// --------------------------------------------------
// 32-bit Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
// --------------------------------------------------
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// --------------------------------------------------
// reference multiply
// returns {underflow, overflow, inf, result}
// --------------------------------------------------
function automatic logic [34:0] mulReference(
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [2:0] mode
);
	logic sign;
	logic [7:0] ea;
	logic [7:0] eb;
	logic [22:0] fa;
	logic [22:0] fb;
	logic [47:0] prod;
	logic [47:0] rem;
	logic [47:0] half;
	logic [24:0] kept;
	logic roundUp;
	int shift;
	int expR;

	sign = a[31] ^ b[31];
	ea = a[30:23];
	eb = b[30:23];
	fa = a[22:0];
	fb = b[22:0];

	// NaN operand, or inf times zero (denormals count as zero)
	if ((ea == 8'hFF && fa != 0) || (eb == 8'hFF && fb != 0) ||
		(ea == 8'hFF && eb == 8'h00) || (eb == 8'hFF && ea == 8'h00)) begin
		return {3'b000, QuietNan};
	end
	if (ea == 8'hFF || eb == 8'hFF) begin
		return {3'b001, sign, 8'hFF, 23'h0};
	end
	if (ea == 8'h00 || eb == 8'h00) begin
		return {3'b000, sign, 31'h0};
	end

	// exact product, leading one at bit 46 or 47
	prod = {24'h0, 1'b1, fa} * {24'h0, 1'b1, fb};
	shift = prod[47] ? 24 : 23;
	expR = int'(ea) + int'(eb) - ExpBias + (prod[47] ? 1 : 0);
	kept = 25'(prod >> shift);
	// discarded tail compared against one half ulp
	rem = prod & ((48'h1 << shift) - 48'h1);
	half = 48'h1 << (shift - 1);

	case (mode)
		RmTowardZero: roundUp = 1'b0;
		RmUp: roundUp = !sign && (rem != 0);
		RmDown: roundUp = sign && (rem != 0);
		RmNearestAway: roundUp = (rem >= half);
		default: roundUp = (rem > half) || (rem == half && kept[0]);
	endcase

	kept = kept + 25'(roundUp);
	// rounding rolled over to 2.0
	if (kept[24]) begin
		kept = kept >> 1;
		expR++;
	end

	if (expR >= 255) begin
		return {3'b010, sign, 8'hFF, 23'h0};
	end
	if (expR <= 0) begin
		return {3'b100, sign, 31'h0};
	end
	return {3'b000, sign, 8'(expR), kept[22:0]};
endfunction

`endif

// File: test/fpMulAxiTb.sv
/*
 * fpMulAxiTb
 * testbench for the AXI4-Lite floating-point multiplier: random and special
 * operands against a reference model, register map and busy/done behavior
 */
`timescale 1ns/1ps
`default_nettype none

module fpMulAxiTb
	import fpPkg::*;
();

	localparam int ClkPeriod = 40;
	localparam int RandomPairs = 300;
	localparam int RangeCount = 20;
	localparam int SpecialCount = 14;
	// multiplies plus register-map and busy tests
	localparam int NumTests = RandomPairs * 5 + SpecialCount + 2 * RangeCount + 12;

	logic clk;
	logic rst;
	logic [4:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [4:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] lfsrState;
	// random stall length in bits, 0 means no stall
	int stallBits;
	int checkCount;
	int errorCount;

	// NaN, inf, zero and denormal cases, last two plain normals
	logic [31:0] specialA [SpecialCount] = '{
		32'h7FC0_0000, 32'h3F80_0000, 32'h7F80_0000, 32'h8000_0000,
		32'h7F80_0000, 32'hFF80_0000, 32'h7F80_0000, 32'h0000_0000,
		32'h8000_0000, 32'h0000_0001, 32'h807F_FFFF, 32'h0040_0000,
		32'h3F80_0000, 32'hC049_0FDB
	};
	logic [31:0] specialB [SpecialCount] = '{
		32'h3F80_0000, 32'h7F80_0001, 32'h0000_0000, 32'hFF80_0000,
		32'hC000_0000, 32'hFF80_0000, 32'h7FC0_0000, 32'h4040_0000,
		32'h40A0_0000, 32'h4000_0000, 32'h4040_0000, 32'h7F80_0000,
		32'h3F80_0000, 32'h3F00_0000
	};

	`include "fpMulModel.svh"

	fpMulAxi #(
		.Latency(MulLatency)
	) u_fpMulAxi (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(ClkPeriod / 2) clk = ~clk;
		end
	end

	// --------------------------------------------------
	// random helpers
	// --------------------------------------------------
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	function automatic logic [2:0] randomMode();
		return 3'(int'(takeBits(3)) % 5);
	endfunction

	// normal operand with exponent in [expLo, expHi]
	function automatic logic [31:0] randomOperand(input int expLo, input int expHi);
		logic [31:0] signBit;
		logic [31:0] expRaw;
		logic [31:0] frac;
		int expVal;
		signBit = takeBits(1);
		expRaw = takeBits(8);
		frac = takeBits(23);
		// short fractions make ties and exact products likely
		if (takeBits(2) == 0) begin
			frac = frac & 32'h007F_0000;
		end
		expVal = expLo + int'(expRaw) % (expHi - expLo + 1);
		return {signBit[0], 8'(expVal), frac[22:0]};
	endfunction

	// status word after completion, done set and busy clear
	function automatic logic [31:0] statusFor(input logic [34:0] expected);
		logic [31:0] word;
		word = '0;
		word[StDone] = 1'b1;
		word[StInf] = expected[32];
		word[StOverflow] = expected[33];
		word[StUnderflow] = expected[34];
		return word;
	endfunction

	// --------------------------------------------------
	// checking
	// --------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("error: %s", what);
	endtask

	// --------------------------------------------------
	// AXI4-Lite master tasks, all return 2 ns after an edge
	// --------------------------------------------------
	task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
		int polls;
		int stall;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		polls = 0;
		do begin
			@(posedge clk);
			#2;
			polls++;
		end while (!(awready && wready) && polls < 16);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!(awready && wready)) begin
			reportFailure($sformatf("write to offset %h was never accepted", addr));
			return;
		end
		polls = 0;
		while (!bvalid && polls < 16) begin
			@(posedge clk);
			#2;
			polls++;
		end
		if (!bvalid) begin
			reportFailure($sformatf("no write response for offset %h", addr));
			return;
		end
		// hold bready low for a while, response must stay up
		stall = int'(takeBits(stallBits));
		repeat (stall) begin
			@(posedge clk);
			#2;
			if (!bvalid) begin
				reportFailure("write response dropped before bready");
			end
		end
		checkValue("bresp", 32'(bresp), 32'h0);
		bready = 1'b1;
		@(posedge clk);
		#2;
		bready = 1'b0;
	endtask

	task automatic readReg(input logic [4:0] addr, output logic [31:0] data);
		int polls;
		int stall;
		data = '0;
		araddr = addr;
		arvalid = 1'b1;
		polls = 0;
		do begin
			@(posedge clk);
			#2;
			polls++;
		end while (!arready && polls < 16);
		arvalid = 1'b0;
		if (!arready) begin
			reportFailure($sformatf("read of offset %h was never accepted", addr));
			return;
		end
		polls = 0;
		while (!rvalid && polls < 16) begin
			@(posedge clk);
			#2;
			polls++;
		end
		if (!rvalid) begin
			reportFailure($sformatf("no read data for offset %h", addr));
			return;
		end
		data = rdata;
		stall = int'(takeBits(stallBits));
		repeat (stall) begin
			@(posedge clk);
			#2;
			if (!rvalid || rdata !== data) begin
				reportFailure("read response changed before rready");
			end
		end
		checkValue("rresp", 32'(rresp), 32'h0);
		rready = 1'b1;
		@(posedge clk);
		#2;
		rready = 1'b0;
	endtask

	// poll status until done is set and busy is clear
	task automatic waitDone(output logic [31:0] status);
		int polls;
		polls = 0;
		status = '0;
		while (!(status[StDone] && !status[StBusy]) && polls < 40) begin
			readReg(AddrStatus, status);
			polls++;
		end
		if (!(status[StDone] && !status[StBusy])) begin
			reportFailure("multiply never reported done");
		end
	endtask

	task automatic runMultiply(input logic [31:0] a, input logic [31:0] b,
		input logic [2:0] mode);
		logic [34:0] expected;
		logic [31:0] status;
		logic [31:0] result;
		expected = mulReference(a, b, mode);
		writeReg(AddrOpA, a);
		writeReg(AddrOpB, b);
		writeReg(AddrMode, 32'(mode));
		writeReg(AddrStart, 32'h1);
		waitDone(status);
		readReg(AddrResult, result);
		checkValue("result", result, expected[31:0]);
		checkValue("status", status, statusFor(expected));
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin : stimulus
		logic [31:0] data;
		logic [31:0] status;
		logic [31:0] opA;
		logic [31:0] opB;
		logic [34:0] expected;
		logic [2:0] mode;

		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		lfsrState = 32'd69067;
		stallBits = 2;
		checkCount = 0;
		errorCount = 0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		// registers clear out of reset
		readReg(AddrStatus, data);
		checkValue("status after reset", data, 32'h0);
		readReg(AddrResult, data);
		checkValue("result after reset", data, 32'h0);
		readReg(AddrOpA, data);
		checkValue("opA after reset", data, 32'h0);

		// register map readback
		opA = takeBits(32);
		opB = takeBits(32);
		mode = randomMode();
		writeReg(AddrOpA, opA);
		writeReg(AddrOpB, opB);
		writeReg(AddrMode, 32'(mode));
		readReg(AddrOpA, data);
		checkValue("opA", data, opA);
		readReg(AddrOpB, data);
		checkValue("opB", data, opB);
		readReg(AddrMode, data);
		checkValue("roundMode", data, 32'(mode));
		readReg(5'h18, data);
		checkValue("rdata at 18", data, 32'h0);
		readReg(5'h1C, data);
		checkValue("rdata at 1C", data, 32'h0);
		readReg(5'h02, data);
		checkValue("rdata at 02", data, 32'h0);

		// special operands
		for (int i = 0; i < SpecialCount; i++) begin
			runMultiply(specialA[i], specialB[i], randomMode());
		end

		// busy right after start, then done on completion
		runMultiply(32'h3F80_0000, 32'h3F80_0000, RmNearestEven);
		stallBits = 0;
		writeReg(AddrOpA, 32'h3FC0_0000);
		writeReg(AddrOpB, 32'h4000_0000);
		writeReg(AddrMode, 32'(RmNearestEven));
		writeReg(AddrStart, 32'h1);
		readReg(AddrStatus, data);
		checkValue("status after start", data, 32'h2);
		waitDone(status);
		checkValue("status at completion", status, 32'h1);
		readReg(AddrResult, data);
		checkValue("result of 1.5 times 2", data, 32'h4040_0000);

		// second start lands while the first still runs
		opA = randomOperand(100, 150);
		opB = randomOperand(100, 150);
		mode = randomMode();
		expected = mulReference(opA, opB, mode);
		writeReg(AddrOpA, opA);
		writeReg(AddrOpB, opB);
		writeReg(AddrMode, 32'(mode));
		writeReg(AddrStart, 32'h1);
		writeReg(AddrStart, 32'h1);
		// a relaunch would still be busy here
		readReg(AddrStatus, status);
		checkValue("status after ignored start", status, statusFor(expected));
		readReg(AddrResult, data);
		checkValue("result after ignored start", data, expected[31:0]);

		// overflow and underflow ranges
		stallBits = 2;
		for (int i = 0; i < RangeCount; i++) begin
			runMultiply(randomOperand(200, 254), randomOperand(200, 254), randomMode());
		end
		for (int i = 0; i < RangeCount; i++) begin
			runMultiply(randomOperand(1, 50), randomOperand(1, 50), randomMode());
		end

		// random pairs in all modes, longer response stalls
		stallBits = 3;
		for (int i = 0; i < RandomPairs; i++) begin
			opA = randomOperand(64, 190);
			opB = randomOperand(64, 190);
			for (int m = 0; m < 5; m++) begin
				runMultiply(opA, opB, 3'(m));
			end
		end

		$display("closing: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(NumTests * 60 * ClkPeriod);
		$display("timeout: the run did not finish within %0d ns", NumTests * 60 * ClkPeriod);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+test
hw/fpPkg.sv
hw/fpDelay.sv
hw/latencyTimer.sv
hw/fpMultiply.sv
hw/fpNormalize.sv
hw/fpRound.sv
hw/mulSequencer.sv
hw/fpMulAxi.sv
test/fpMulAxiTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fpMulAxi testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module fpMulAxiTb -f list.f -Mdir obj_dir -o fpMulAxiSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/fpMulAxiSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Result: PASSED" "$LOG"; then
	exit 0
fi

echo "pass message not found in $LOG"
exit 1
